/* all.f */
verilog/csr_pkg.sv
verilog/csr_access.sv
verilog/trap_detect.sv
verilog/machine_csr_regs.sv
verilog/riscv_csrfile.sv
sim/tb_clk_gen.sv
sim/tb_riscv_csrfile.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_riscv_csrfile
FILELIST = all.f
OBJ_DIR  = obj_dir
LOG      = sim.log
PASS_MSG = Simulation completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

sim:
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* sim/tb_riscv_csrfile.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_riscv_csrfile;
  import csr_pkg::*;

  localparam int TEST_CYCLES = 100;               // Reset plus all test steps rounded up
  localparam int CYCLE_LIMIT = 4 * TEST_CYCLES;

  typedef struct packed {
    logic [11:0] address;
    csr_op_e     op;
    logic [63:0] wdata;
    exc_flags_t  exc;
    logic [63:0] pc;
    logic [63:0] alu_addr;
    logic [31:0] inst;
    logic        flush;
    logic        globstall;
    logic        timer_int;
    logic        ext_int;
  } stim_t;

  logic        clk;
  logic        rst;
  stim_t       cur;   // Next values from the test
  stim_t       drv;   // Values on the DUT pins
  logic [63:0] rdata;
  logic [63:0] ret_addr;
  logic [63:0] trap_addr;
  logic        go_to_trap;
  logic        ret_from_trap;
  priv_lvl_e   privlvl;
  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;

  tb_clk_gen #(
    .PERIOD_NS    (20),
    .RESET_CYCLES (16)
  ) u_clk_gen (
    .o_clk (clk),
    .o_rst (rst)
  );

  riscv_csrfile #(
    .MXLEN        (64),
    .SUPPORT_USER (1)
  ) dut (
    .i_riscv_csr_clk              (clk),
    .i_riscv_csr_rst              (rst),
    .i_riscv_csr_address          (drv.address),
    .i_riscv_csr_op               (drv.op),
    .i_riscv_csr_wdata            (drv.wdata),
    .i_riscv_csr_exc              (drv.exc),
    .i_riscv_csr_external_int     (drv.ext_int),
    .i_riscv_csr_timer_int        (drv.timer_int),
    .i_riscv_csr_pc               (drv.pc),
    .i_riscv_csr_address_alu      (drv.alu_addr),
    .i_riscv_csr_inst             (drv.inst),
    .i_riscv_csr_flush            (drv.flush),
    .i_riscv_csr_globstall        (drv.globstall),
    .o_riscv_csr_rdata            (rdata),
    .o_riscv_csr_return_address   (ret_addr),
    .o_riscv_csr_trap_address     (trap_addr),
    .o_riscv_csr_go_to_trap       (go_to_trap),
    .o_riscv_csr_return_from_trap (ret_from_trap),
    .o_riscv_csr_privlvl          (privlvl)
  );

  function automatic logic [63:0] rand64();
    return {$urandom, $urandom};
  endfunction

  function automatic logic [63:0] mstatus_word(input logic mie, input logic mpie,
                                               input logic [1:0] mpp);
    logic [63:0] w;
    w                   = '0;
    w[MSTATUS_MIE]      = mie;
    w[MSTATUS_MPIE]     = mpie;
    w[MSTATUS_MPP +: 2] = mpp;
    return w;
  endfunction

  function automatic logic [63:0] cause_word(input logic intr, input logic [3:0] code);
    return {intr, 59'b0, code};
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    checks++;
    assert (got === exp)
    else
    begin
      errors++;
      $display("error: %s = 0x%016h, expected 0x%016h", name, got, exp);
    end
  endtask

  // One cycle of stimulus with outputs checked at the falling edge
  task automatic drive_cycle();
    @(posedge clk);
    drv <= cur;
    @(negedge clk);
    cur.op    = CSR_NONE;   // Ops and exceptions last one cycle
    cur.exc   = '0;
    cur.wdata = '0;
  endtask

  task automatic read_expect(input logic [11:0] addr, input logic [63:0] exp,
                             input string name);
    cur.address = addr;
    cur.op      = CSR_READ;
    drive_cycle();
    check_value(name, rdata, exp);
    check_value("go_to_trap", 64'(go_to_trap), 64'd0);
    check_value("return_from_trap", 64'(ret_from_trap), 64'd0);
  endtask

  task automatic write_csr(input logic [11:0] addr, input csr_op_e op, input logic [63:0] data);
    cur.address = addr;
    cur.op      = op;
    cur.wdata   = data;
    drive_cycle();
    check_value("go_to_trap", 64'(go_to_trap), 64'd0);
  endtask

  task automatic expect_trap(input logic [63:0] exp_addr);
    check_value("go_to_trap", 64'(go_to_trap), 64'd1);
    check_value("trap_address", trap_addr, exp_addr);
  endtask

  // A stalled pipeline never takes a trap
  assert property (@(negedge clk) disable iff (rst) drv.globstall |-> !go_to_trap)
  else
  begin
    errors++;
    $display("error: go_to_trap = 0x%0h during globstall, expected 0x0", go_to_trap);
  end

  always @(posedge clk)
  begin
    cycles++;
    if (cycles >= CYCLE_LIMIT)
    begin
      $display("timeout: tests did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Simulation failed");
      $finish;
    end
  end

  initial
  begin
    logic [63:0] m_scratch;
    logic [63:0] r;
    logic [63:0] base;
    void'($urandom(11));
    cur = '0;
    drv <= '0;
    @(negedge rst);

    // Reset values
    drive_cycle();
    check_value("privlvl", 64'(privlvl), 64'(PRIV_LVL_M));
    check_value("go_to_trap", 64'(go_to_trap), 64'd0);
    read_expect(MSTATUS, 64'd0, "mstatus");
    read_expect(MTVEC, {MTVEC_RESET, 2'b00}, "mtvec");
    read_expect(MISA, ISA_CODE, "misa");
    read_expect(MSCRATCH, 64'd0, "mscratch");
    read_expect(MEPC, 64'd0, "mepc");
    read_expect(MCAUSE, 64'd0, "mcause");
    read_expect(MIE, 64'd0, "mie");

    // Write, set, clear and read on mscratch
    m_scratch = rand64();
    write_csr(MSCRATCH, CSR_WRITE, m_scratch);
    read_expect(MSCRATCH, m_scratch, "mscratch");
    r = rand64();
    write_csr(MSCRATCH, CSR_SET, r);
    check_value("rdata", rdata, m_scratch);   // Old value comes back
    m_scratch = m_scratch | r;
    read_expect(MSCRATCH, m_scratch, "mscratch");
    r = rand64();
    write_csr(MSCRATCH, CSR_CLEAR, r);
    m_scratch = m_scratch & ~r;
    read_expect(MSCRATCH, m_scratch, "mscratch");
    write_csr(MSCRATCH, CSR_READ, rand64());
    read_expect(MSCRATCH, m_scratch, "mscratch");
    r = rand64() | 64'd1;
    write_csr(MEPC, CSR_WRITE, r);
    read_expect(MEPC, r & ~64'd1, "mepc");
    check_value("return_address", ret_addr, r & ~64'd1);

    // Write to a read-only id register
    cur.pc      = rand64() & ~64'h3;
    cur.inst    = $urandom;
    cur.address = MHARTID;
    cur.op      = CSR_WRITE;
    cur.wdata   = rand64();
    drive_cycle();
    expect_trap({MTVEC_RESET, 2'b00});
    read_expect(MCAUSE, cause_word(1'b0, ILLEGAL_INST), "mcause");
    read_expect(MTVAL, 64'(cur.inst), "mtval");
    check_value("return_address", ret_addr, cur.pc);
    read_expect(MSTATUS, mstatus_word(1'b0, 1'b0, PRIV_LVL_M), "mstatus");

    // MRET to U, then ecall back into M
    write_csr(MSTATUS, CSR_WRITE, mstatus_word(1'b0, 1'b0, PRIV_LVL_U));
    cur.op = MRET;
    drive_cycle();
    check_value("return_from_trap", 64'(ret_from_trap), 64'd1);
    check_value("go_to_trap", 64'(go_to_trap), 64'd0);
    drive_cycle();
    check_value("privlvl", 64'(privlvl), 64'(PRIV_LVL_U));
    cur.pc          = rand64() & ~64'h3;
    cur.exc.ecall_u = 1'b1;
    drive_cycle();
    expect_trap({MTVEC_RESET, 2'b00});
    read_expect(MCAUSE, cause_word(1'b0, ECALL_U), "mcause");
    check_value("privlvl", 64'(privlvl), 64'(PRIV_LVL_M));
    check_value("return_address", ret_addr, cur.pc);
    read_expect(MSTATUS, mstatus_word(1'b0, 1'b0, PRIV_LVL_U), "mstatus");
    cur.op = MRET;
    drive_cycle();
    cur.inst    = $urandom;
    cur.address = MSCRATCH;   // M-level register read from U
    cur.op      = CSR_READ;
    drive_cycle();
    expect_trap({MTVEC_RESET, 2'b00});
    read_expect(MCAUSE, cause_word(1'b0, ILLEGAL_INST), "mcause");
    read_expect(MTVAL, 64'(cur.inst), "mtval");

    // Vectored interrupts
    base = 64'h0000_0000_8000_1000;
    write_csr(MTVEC, CSR_WRITE, base | 64'd1);
    read_expect(MTVEC, base | 64'd1, "mtvec");
    write_csr(MIE, CSR_WRITE, 64'd1 << MIE_MTI);
    write_csr(MSTATUS, CSR_WRITE, mstatus_word(1'b1, 1'b0, PRIV_LVL_U));
    cur.pc        = rand64() & ~64'h3;
    cur.timer_int = 1'b1;
    drive_cycle();
    check_value("go_to_trap", 64'(go_to_trap), 64'd0);   // mip not sampled yet
    drive_cycle();
    expect_trap(base + 64'd28);
    read_expect(MCAUSE, cause_word(1'b1, MTI), "mcause");
    read_expect(MIP, 64'd1 << MIE_MTI, "mip");
    read_expect(MEPC, cur.pc, "mepc");
    read_expect(MTVAL, 64'd0, "mtval");
    read_expect(MSTATUS, mstatus_word(1'b0, 1'b1, PRIV_LVL_M), "mstatus");
    cur.timer_int = 1'b0;
    drive_cycle();
    drive_cycle();
    write_csr(MIE, CSR_WRITE, (64'd1 << MIE_MTI) | (64'd1 << MIE_MEI));
    write_csr(MSTATUS, CSR_WRITE, mstatus_word(1'b1, 1'b0, PRIV_LVL_U));
    cur.timer_int = 1'b1;
    cur.ext_int   = 1'b1;
    drive_cycle();
    drive_cycle();
    expect_trap(base + 64'd44);   // External wins
    read_expect(MCAUSE, cause_word(1'b1, MEI), "mcause");
    cur.ext_int = 1'b0;
    cur.op      = MRET;
    drive_cycle();
    check_value("return_from_trap", 64'(ret_from_trap), 64'd1);
    drive_cycle();
    expect_trap(base + 64'd28);   // Timer still pending
    cur.timer_int = 1'b0;
    read_expect(MCAUSE, cause_word(1'b1, MTI), "mcause");

    // Stall blocks traps and writes while flush blocks only traps
    cur.globstall        = 1'b1;
    cur.exc.illegal_inst = 1'b1;
    drive_cycle();
    write_csr(MSCRATCH, CSR_WRITE, rand64());
    cur.op = MRET;
    drive_cycle();
    check_value("return_from_trap", 64'(ret_from_trap), 64'd0);
    cur.globstall = 1'b0;
    read_expect(MSCRATCH, m_scratch, "mscratch");
    check_value("privlvl", 64'(privlvl), 64'(PRIV_LVL_M));
    cur.flush       = 1'b1;
    cur.exc.ecall_m = 1'b1;
    drive_cycle();
    check_value("go_to_trap", 64'(go_to_trap), 64'd0);
    m_scratch = rand64();
    write_csr(MSCRATCH, CSR_WRITE, m_scratch);
    cur.flush = 1'b0;
    read_expect(MSCRATCH, m_scratch, "mscratch");
    read_expect(MCAUSE, cause_word(1'b1, MTI), "mcause");

    // A trap in the same cycle as a write wins over it
    cur.alu_addr            = rand64() | 64'd1;
    cur.exc.load_misaligned = 1'b1;
    cur.address             = MSCRATCH;
    cur.op                  = CSR_WRITE;
    cur.wdata               = rand64();
    drive_cycle();
    expect_trap(base);   // Exceptions use the base in vectored mode
    read_expect(MSCRATCH, m_scratch, "mscratch");
    read_expect(MCAUSE, cause_word(1'b0, LOAD_MISALIGNED), "mcause");
    read_expect(MTVAL, cur.alu_addr, "mtval");

    $display("checks: %0d errors: %0d", checks, errors);
    if (errors == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

/* sim/tb_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD_NS    = 20,
  parameter int RESET_CYCLES = 16
) (
  output logic o_clk,
  output logic o_rst
);

  initial
  begin
    o_clk = 1'b0;
    forever #(PERIOD_NS / 2) o_clk = ~o_clk;
  end

  initial
  begin
    o_rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge o_clk);
    o_rst <= 1'b0;   // Released on a rising edge like the other inputs
  end

endmodule

`default_nettype wire

/* verilog/riscv_csrfile.sv */
`timescale 1ns/1ps
`default_nettype none

module riscv_csrfile #(
  parameter int MXLEN        = 64,
  parameter int SUPPORT_USER = 1
) (
  input  wire logic                 i_riscv_csr_clk,
  input  wire logic                 i_riscv_csr_rst,
  input  wire logic [11:0]          i_riscv_csr_address,
  input  wire csr_pkg::csr_op_e     i_riscv_csr_op,
  input  wire logic [MXLEN-1:0]     i_riscv_csr_wdata,
  input  wire csr_pkg::exc_flags_t  i_riscv_csr_exc,
  input  wire logic                 i_riscv_csr_external_int,
  input  wire logic                 i_riscv_csr_timer_int,
  input  wire logic [MXLEN-1:0]     i_riscv_csr_pc,
  input  wire logic [MXLEN-1:0]     i_riscv_csr_address_alu,
  input  wire logic [31:0]          i_riscv_csr_inst,
  input  wire logic                 i_riscv_csr_flush,
  input  wire logic                 i_riscv_csr_globstall,
  output logic [MXLEN-1:0]          o_riscv_csr_rdata,
  output logic [MXLEN-1:0]          o_riscv_csr_return_address,
  output logic [MXLEN-1:0]          o_riscv_csr_trap_address,
  output logic                      o_riscv_csr_go_to_trap,
  output logic                      o_riscv_csr_return_from_trap,
  output csr_pkg::priv_lvl_e        o_riscv_csr_privlvl
);
  import csr_pkg::*;

  priv_lvl_e        priv;
  mstatus_t         mstatus;
  irq_t             mie;
  irq_t             mip;
  logic [MXLEN-1:0] mtvec;
  logic [MXLEN-1:0] mscratch;
  logic [MXLEN-1:0] mepc;
  logic [MXLEN-1:0] mtval;
  logic             mcause_int;
  logic [3:0]       mcause_code;
  logic             wr_en;
  logic [MXLEN-1:0] wr_data;
  logic             mret;
  logic             illegal_csr;
  trap_info_t       trap;

  csr_access #(
    .MXLEN (MXLEN)
  ) u_csr_access (
    .i_address     (i_riscv_csr_address),
    .i_op          (i_riscv_csr_op),
    .i_wdata       (i_riscv_csr_wdata),
    .i_globstall   (i_riscv_csr_globstall),
    .i_priv        (priv),
    .i_mstatus     (mstatus),
    .i_mie         (mie),
    .i_mip         (mip),
    .i_mtvec       (mtvec),
    .i_mscratch    (mscratch),
    .i_mepc        (mepc),
    .i_mtval       (mtval),
    .i_mcause_int  (mcause_int),
    .i_mcause_code (mcause_code),
    .o_rdata       (o_riscv_csr_rdata),
    .o_wr_en       (wr_en),
    .o_wr_data     (wr_data),
    .o_mret        (mret),
    .o_illegal_csr (illegal_csr)
  );

  trap_detect #(
    .MXLEN (MXLEN)
  ) u_trap_detect (
    .i_exc         (i_riscv_csr_exc),
    .i_illegal_csr (illegal_csr),
    .i_flush       (i_riscv_csr_flush),
    .i_globstall   (i_riscv_csr_globstall),
    .i_priv        (priv),
    .i_mstatus     (mstatus),
    .i_mie         (mie),
    .i_mip         (mip),
    .i_mtvec       (mtvec),
    .o_trap        (trap),
    .o_trap_addr   (o_riscv_csr_trap_address)
  );

  machine_csr_regs #(
    .MXLEN        (MXLEN),
    .SUPPORT_USER (SUPPORT_USER)
  ) u_machine_csr_regs (
    .i_riscv_csr_clk (i_riscv_csr_clk),
    .i_riscv_csr_rst (i_riscv_csr_rst),
    .i_trap          (trap),
    .i_mret          (mret),
    .i_wr_en         (wr_en),
    .i_wr_data       (wr_data),
    .i_address       (i_riscv_csr_address),
    .i_pc            (i_riscv_csr_pc),
    .i_alu_addr      (i_riscv_csr_address_alu),
    .i_inst          (i_riscv_csr_inst),
    .i_timer_int     (i_riscv_csr_timer_int),
    .i_external_int  (i_riscv_csr_external_int),
    .o_priv          (priv),
    .o_mstatus       (mstatus),
    .o_mie           (mie),
    .o_mip           (mip),
    .o_mtvec         (mtvec),
    .o_mscratch      (mscratch),
    .o_mepc          (mepc),
    .o_mtval         (mtval),
    .o_mcause_int    (mcause_int),
    .o_mcause_code   (mcause_code)
  );

  assign o_riscv_csr_return_address   = mepc;
  assign o_riscv_csr_go_to_trap       = trap.take;
  assign o_riscv_csr_return_from_trap = mret;
  assign o_riscv_csr_privlvl          = priv;

endmodule

`default_nettype wire

/* verilog/machine_csr_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module machine_csr_regs #(
  parameter int MXLEN        = 64,
  parameter int SUPPORT_USER = 1
) (
  input  wire logic                 i_riscv_csr_clk,
  input  wire logic                 i_riscv_csr_rst,
  input  wire csr_pkg::trap_info_t  i_trap,
  input  wire logic                 i_mret,
  input  wire logic                 i_wr_en,
  input  wire logic [MXLEN-1:0]     i_wr_data,
  input  wire logic [11:0]          i_address,
  input  wire logic [MXLEN-1:0]     i_pc,
  input  wire logic [MXLEN-1:0]     i_alu_addr,
  input  wire logic [31:0]          i_inst,
  input  wire logic                 i_timer_int,
  input  wire logic                 i_external_int,
  output csr_pkg::priv_lvl_e        o_priv,
  output csr_pkg::mstatus_t         o_mstatus,
  output csr_pkg::irq_t             o_mie,
  output csr_pkg::irq_t             o_mip,
  output logic [MXLEN-1:0]          o_mtvec,
  output logic [MXLEN-1:0]          o_mscratch,
  output logic [MXLEN-1:0]          o_mepc,
  output logic [MXLEN-1:0]          o_mtval,
  output logic                      o_mcause_int,
  output logic [3:0]                o_mcause_code
);
  import csr_pkg::*;

  priv_lvl_e        priv_q;
  mstatus_t         mstatus_q;
  irq_t             mie_q;
  irq_t             mip_q;
  logic [MXLEN-3:0] mtvec_base;
  logic             mtvec_mode;   // 1 is vectored
  logic [MXLEN-1:0] mscratch_q;
  logic [MXLEN-1:0] mepc_q;
  logic [MXLEN-1:0] mtval_q;
  logic             mcause_int_q;
  logic [3:0]       mcause_code_q;

  logic      wr_ok;
  logic      wr_mstatus;
  logic      wr_mie;
  logic      wr_mtvec;
  logic      wr_mscratch;
  logic      wr_mepc;
  logic      wr_mcause;
  logic      wr_mtval;
  priv_lvl_e wr_mpp;

  assign wr_ok       = i_wr_en && !i_trap.take;   // A taken trap cancels the write
  assign wr_mstatus  = wr_ok && (i_address == MSTATUS);
  assign wr_mie      = wr_ok && (i_address == MIE);
  assign wr_mtvec    = wr_ok && (i_address == MTVEC);
  assign wr_mscratch = wr_ok && (i_address == MSCRATCH);
  assign wr_mepc     = wr_ok && (i_address == MEPC);
  assign wr_mcause   = wr_ok && (i_address == MCAUSE);
  assign wr_mtval    = wr_ok && (i_address == MTVAL);

  // Only U and M exist so other mpp values fold to M
  always_comb
  begin
    if ((SUPPORT_USER != 0) && (i_wr_data[MSTATUS_MPP +: 2] == PRIV_LVL_U))
      wr_mpp = PRIV_LVL_U;
    else
      wr_mpp = PRIV_LVL_M;
  end

  always_ff @(posedge i_riscv_csr_clk or posedge i_riscv_csr_rst)
  begin
    if (i_riscv_csr_rst)
      priv_q <= PRIV_LVL_M;
    else if (i_trap.take)
      priv_q <= PRIV_LVL_M;   // All traps are handled in M
    else if (i_mret)
      priv_q <= mstatus_q.mpp;
  end

  always_ff @(posedge i_riscv_csr_clk or posedge i_riscv_csr_rst)
  begin
    if (i_riscv_csr_rst)
      mstatus_q <= '0;
    else if (i_trap.take)
    begin
      mstatus_q.mpie <= mstatus_q.mie;
      mstatus_q.mie  <= 1'b0;   // Handler starts masked
      mstatus_q.mpp  <= priv_q;
    end
    else if (i_mret)
    begin
      mstatus_q.mie  <= mstatus_q.mpie;
      mstatus_q.mpie <= 1'b1;
      mstatus_q.mpp  <= (SUPPORT_USER != 0) ? PRIV_LVL_U : PRIV_LVL_M;
    end
    else if (wr_mstatus)
    begin
      mstatus_q.mie  <= i_wr_data[MSTATUS_MIE];
      mstatus_q.mpie <= i_wr_data[MSTATUS_MPIE];
      mstatus_q.mpp  <= wr_mpp;
    end
  end

  always_ff @(posedge i_riscv_csr_clk or posedge i_riscv_csr_rst)
  begin
    if (i_riscv_csr_rst)
    begin
      mie_q <= '0;
      mip_q <= '0;
    end
    else
    begin
      mip_q.mti <= i_timer_int;   // Pending bits follow the lines
      mip_q.mei <= i_external_int;
      if (wr_mie)
      begin
        mie_q.mti <= i_wr_data[MIE_MTI];
        mie_q.mei <= i_wr_data[MIE_MEI];
      end
    end
  end

  always_ff @(posedge i_riscv_csr_clk or posedge i_riscv_csr_rst)
  begin
    if (i_riscv_csr_rst)
    begin
      mtvec_base <= MTVEC_RESET[MXLEN-3:0];
      mtvec_mode <= 1'b0;
    end
    else if (wr_mtvec)
    begin
      mtvec_mode <= i_wr_data[0];
      if (i_wr_data[0])
        mtvec_base <= {i_wr_data[MXLEN-1:8], 6'b0};   // Table on 256 bytes
      else
        mtvec_base <= i_wr_data[MXLEN-1:2];
    end
  end

  always_ff @(posedge i_riscv_csr_clk or posedge i_riscv_csr_rst)
  begin
    if (i_riscv_csr_rst)
      mscratch_q <= '0;
    else if (wr_mscratch)
      mscratch_q <= i_wr_data;
  end

  always_ff @(posedge i_riscv_csr_clk or posedge i_riscv_csr_rst)
  begin
    if (i_riscv_csr_rst)
    begin
      mepc_q        <= '0;
      mtval_q       <= '0;
      mcause_int_q  <= 1'b0;
      mcause_code_q <= '0;
    end
    else if (i_trap.take)
    begin
      mepc_q        <= i_pc;
      mcause_int_q  <= i_trap.is_interrupt;
      mcause_code_q <= i_trap.code;
      case (i_trap.tval_sel)
        TVAL_ADDR : mtval_q <= i_alu_addr;
        TVAL_INST : mtval_q <= MXLEN'(i_inst);   // Zero extended
        default   : mtval_q <= '0;
      endcase
    end
    else
    begin
      if (wr_mepc)
        mepc_q <= {i_wr_data[MXLEN-1:1], 1'b0};
      if (wr_mtval)
        mtval_q <= i_wr_data;
      if (wr_mcause)
      begin
        mcause_int_q  <= i_wr_data[MXLEN-1];
        mcause_code_q <= i_wr_data[3:0];
      end
    end
  end

  assign o_priv        = priv_q;
  assign o_mstatus     = mstatus_q;
  assign o_mie         = mie_q;
  assign o_mip         = mip_q;
  assign o_mtvec       = {mtvec_base, 1'b0, mtvec_mode};
  assign o_mscratch    = mscratch_q;
  assign o_mepc        = mepc_q;
  assign o_mtval       = mtval_q;
  assign o_mcause_int  = mcause_int_q;
  assign o_mcause_code = mcause_code_q;

endmodule

`default_nettype wire

/* verilog/trap_detect.sv */
`timescale 1ns/1ps
`default_nettype none

module trap_detect #(
  parameter int MXLEN = 64
) (
  input  wire csr_pkg::exc_flags_t  i_exc,
  input  wire logic                 i_illegal_csr,
  input  wire logic                 i_flush,
  input  wire logic                 i_globstall,
  input  wire csr_pkg::priv_lvl_e   i_priv,
  input  wire csr_pkg::mstatus_t    i_mstatus,
  input  wire csr_pkg::irq_t        i_mie,
  input  wire csr_pkg::irq_t        i_mip,
  input  wire logic [MXLEN-1:0]     i_mtvec,
  output csr_pkg::trap_info_t       o_trap,
  output logic [MXLEN-1:0]          o_trap_addr
);
  import csr_pkg::*;

  irq_t             pending;
  logic             irq_enable;
  logic             is_int;
  logic             is_exc;
  logic [3:0]       int_code;
  logic [3:0]       exc_code;
  tval_sel_e        exc_tval;
  logic [MXLEN-1:0] base_addr;

  assign pending    = i_mip & i_mie;
  assign irq_enable = (i_priv == PRIV_LVL_U) || i_mstatus.mie;   // U mode is always interruptible
  assign is_int     = (pending.mei || pending.mti) && irq_enable;
  assign int_code   = pending.mei ? MEI : MTI;   // External first
  assign is_exc     = (|i_exc) || i_illegal_csr;

  always_comb
  begin
    exc_code = STORE_MISALIGNED;
    exc_tval = TVAL_NONE;
    if (i_exc.illegal_inst || i_illegal_csr)
    begin
      exc_code = ILLEGAL_INST;
      exc_tval = TVAL_INST;
    end
    else if (i_exc.inst_misaligned)
      exc_code = INST_MISALIGNED;
    else if (i_exc.ecall_m)
      exc_code = ECALL_M;
    else if (i_exc.ecall_u)
      exc_code = ECALL_U;
    else if (i_exc.load_misaligned)
    begin
      exc_code = LOAD_MISALIGNED;
      exc_tval = TVAL_ADDR;
    end
    else if (i_exc.store_misaligned)
      exc_tval = TVAL_ADDR;
  end

  always_comb
  begin
    o_trap.take         = (is_int || is_exc) && !i_flush && !i_globstall;
    o_trap.is_interrupt = is_int;
    if (is_int)
    begin
      o_trap.code     = int_code;   // Interrupts beat exceptions
      o_trap.tval_sel = TVAL_NONE;
    end
    else
    begin
      o_trap.code     = exc_code;
      o_trap.tval_sel = exc_tval;
    end
  end

  assign base_addr = {i_mtvec[MXLEN-1:2], 2'b00};

  // Vectored mode offsets interrupts only
  assign o_trap_addr = (i_mtvec[0] && is_int) ? base_addr + (MXLEN'(int_code) << 2)
                                              : base_addr;

endmodule

`default_nettype wire

/* verilog/csr_access.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_access #(
  parameter int MXLEN = 64
) (
  input  wire logic [11:0]          i_address,
  input  wire csr_pkg::csr_op_e     i_op,
  input  wire logic [MXLEN-1:0]     i_wdata,
  input  wire logic                 i_globstall,
  input  wire csr_pkg::priv_lvl_e   i_priv,
  input  wire csr_pkg::mstatus_t    i_mstatus,
  input  wire csr_pkg::irq_t        i_mie,
  input  wire csr_pkg::irq_t        i_mip,
  input  wire logic [MXLEN-1:0]     i_mtvec,
  input  wire logic [MXLEN-1:0]     i_mscratch,
  input  wire logic [MXLEN-1:0]     i_mepc,
  input  wire logic [MXLEN-1:0]     i_mtval,
  input  wire logic                 i_mcause_int,
  input  wire logic [3:0]           i_mcause_code,
  output logic [MXLEN-1:0]          o_rdata,
  output logic                      o_wr_en,
  output logic [MXLEN-1:0]          o_wr_data,
  output logic                      o_mret,
  output logic                      o_illegal_csr
);
  import csr_pkg::*;

  logic [MXLEN-1:0] rdata;
  logic             is_write;       // Write, set or clear
  logic             is_csr;         // Any op that touches a CSR
  logic             unknown_addr;
  logic             ro_write;
  logic             priv_fault;

  assign is_write = (i_op == CSR_WRITE) || (i_op == CSR_SET) || (i_op == CSR_CLEAR);
  assign is_csr   = is_write || (i_op == CSR_READ);

  always_comb
  begin
    rdata        = '0;
    unknown_addr = 1'b0;
    case (i_address)
      MVENDORID, MARCHID, MIMPID, MHARTID : rdata = '0;   // Hardwired ids
      MISA :
      begin
        rdata               = ISA_CODE[MXLEN-1:0];
        rdata[MXLEN-1 -: 2] = (MXLEN == 32) ? 2'b01 : 2'b10;   // MXL tracks width
      end
      MSTATUS :
      begin
        rdata[MSTATUS_MIE]      = i_mstatus.mie;
        rdata[MSTATUS_MPIE]     = i_mstatus.mpie;
        rdata[MSTATUS_MPP +: 2] = i_mstatus.mpp;
      end
      MIE :
      begin
        rdata[MIE_MTI] = i_mie.mti;
        rdata[MIE_MEI] = i_mie.mei;
      end
      MIP :
      begin
        rdata[MIE_MTI] = i_mip.mti;
        rdata[MIE_MEI] = i_mip.mei;
      end
      MTVEC    : rdata = i_mtvec;
      MSCRATCH : rdata = i_mscratch;
      MEPC     : rdata = i_mepc;
      MTVAL    : rdata = i_mtval;
      MCAUSE :
      begin
        rdata[MXLEN-1] = i_mcause_int;   // Interrupt flag in the top bit
        rdata[3:0]     = i_mcause_code;
      end
      default : unknown_addr = 1'b1;
    endcase
  end

  // Set and clear work on the current register value
  always_comb
  begin
    case (i_op)
      CSR_SET   : o_wr_data = rdata | i_wdata;
      CSR_CLEAR : o_wr_data = rdata & ~i_wdata;
      default   : o_wr_data = i_wdata;
    endcase
  end

  assign ro_write   = is_write && (i_address[11:10] == 2'b11);
  assign priv_fault = i_address[9:8] > i_priv;   // Needed level is in bits 9 and 8

  assign o_illegal_csr = is_csr && (unknown_addr || ro_write || priv_fault);
  assign o_wr_en       = is_write && !i_globstall && !o_illegal_csr;
  assign o_mret        = (i_op == MRET) && !i_globstall;
  assign o_rdata       = rdata;

endmodule

`default_nettype wire

/* verilog/csr_pkg.sv */
`default_nettype none

package csr_pkg;

  typedef enum logic [2:0] {
    CSR_NONE  = 3'd0,
    CSR_WRITE = 3'd1,
    CSR_SET   = 3'd2,
    CSR_CLEAR = 3'd3,
    CSR_READ  = 3'd4,
    MRET      = 3'd6   // Code 5 reserved
  } csr_op_e;

  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'd0,
    PRIV_LVL_M = 2'd3
  } priv_lvl_e;

  // Source of the value loaded into mtval on a trap
  typedef enum logic [1:0] {
    TVAL_NONE = 2'd0,
    TVAL_ADDR = 2'd1,
    TVAL_INST = 2'd2
  } tval_sel_e;

  localparam logic [11:0] MVENDORID = 12'hF11;
  localparam logic [11:0] MARCHID   = 12'hF12;
  localparam logic [11:0] MIMPID    = 12'hF13;
  localparam logic [11:0] MHARTID   = 12'hF14;
  localparam logic [11:0] MSTATUS   = 12'h300;
  localparam logic [11:0] MISA      = 12'h301;
  localparam logic [11:0] MIE       = 12'h304;
  localparam logic [11:0] MTVEC     = 12'h305;
  localparam logic [11:0] MSCRATCH  = 12'h340;
  localparam logic [11:0] MEPC      = 12'h341;
  localparam logic [11:0] MCAUSE    = 12'h342;
  localparam logic [11:0] MTVAL     = 12'h343;
  localparam logic [11:0] MIP       = 12'h344;

  localparam logic [3:0] INST_MISALIGNED  = 4'd0;
  localparam logic [3:0] ILLEGAL_INST     = 4'd2;
  localparam logic [3:0] LOAD_MISALIGNED  = 4'd4;
  localparam logic [3:0] STORE_MISALIGNED = 4'd6;
  localparam logic [3:0] ECALL_U          = 4'd8;
  localparam logic [3:0] ECALL_M          = 4'd11;
  localparam logic [3:0] MTI              = 4'd7;   // Interrupt causes
  localparam logic [3:0] MEI              = 4'd11;

  localparam int MSTATUS_MIE  = 3;
  localparam int MSTATUS_MPIE = 7;
  localparam int MSTATUS_MPP  = 11;   // Low bit of the two bit field
  localparam int MIE_MTI      = 7;    // Same positions in mip
  localparam int MIE_MEI      = 11;

  localparam logic [63:0] ISA_CODE    = 64'h8000_0000_0010_1100;   // RV64 I M U
  localparam logic [61:0] MTVEC_RESET = 62'h12;

  typedef struct packed {
    logic      mie;
    logic      mpie;
    priv_lvl_e mpp;
  } mstatus_t;

  typedef struct packed {
    logic mei;
    logic mti;
  } irq_t;

  typedef struct packed {
    logic illegal_inst;
    logic ecall_u;
    logic ecall_m;
    logic inst_misaligned;
    logic load_misaligned;
    logic store_misaligned;
  } exc_flags_t;

  typedef struct packed {
    logic       take;
    logic       is_interrupt;
    logic [3:0] code;
    tval_sel_e  tval_sel;
  } trap_info_t;

endpackage

`default_nettype wire
